//--- source/mem_req_pkg.sv
// ==========================================================
// Shared types and helpers of the memory request queue.
// Holds the request struct, the opcode and size encodings,
// the width constants and the byte-lane helpers.
// Every RTL module imports it with a wildcard import, and the
// testbench model uses the same helpers.
// ==========================================================

package mem_req_pkg;

	// ==========================================================
	// Widths
	// ==========================================================

	// Byte address width of a request
	localparam int ADR_W = 32;
	// One doubleword of data per request
	localparam int DAT_W = 64;
	// Transaction id width, used for retry suppression
	localparam int TID_W = 8;
	// Byte lanes in one doubleword
	localparam int LANES = DAT_W / 8;

	// ==========================================================
	// Encodings
	// ==========================================================

	// Memory operation of a request
	// MR_LOAD sign-extends the loaded value and MR_LOADZ zero-extends it
	typedef enum logic [1:0] {
		MR_LOAD  = 2'd0,
		MR_LOADZ = 2'd1,
		MR_STORE = 2'd2
	} mem_func_e;

	// Access size in bytes is 1 << size
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} mem_size_e;

	// One memory request as it travels through the queue
	// Store data is right-justified so dat[7:0] belongs to the byte at adr
	typedef struct packed {
		logic [TID_W-1:0] tid;
		mem_func_e        func;
		mem_size_e        size;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
	} mem_request_t;

	// ==========================================================
	// Byte lanes
	// ==========================================================

	// Lanes covered by an access of the given size starting at lane 0
	function automatic logic [LANES-1:0] size_mask(input mem_size_e sz);
		case (sz)
			SZ_BYTE:  return 8'h01;
			SZ_WYDE:  return 8'h03;
			SZ_TETRA: return 8'h0f;
			SZ_OCTA:  return 8'hff;
			default:  return 8'hff;
		endcase
	endfunction

	// Lanes of the doubleword touched by a request
	// Requests are naturally aligned so the shift never runs off the top
	function automatic logic [LANES-1:0] lane_sel(input mem_request_t r);
		return size_mask(r.size) << r.adr[2:0];
	endfunction

endpackage

//--- source/fwd_search.sv
// ==========================================================
// Store-to-load forwarding search for one request port.
// Compares the offered load against a snapshot of the queue
// and returns the forwarded data when one queued store holds
// every byte of the load. Purely combinational, so found and
// ldo are valid in the same cycle as req.
// ==========================================================

module fwd_search
	import mem_req_pkg::*;
#(
	parameter int QDEP = 8
) (
	input  mem_request_t            req,
	input  mem_request_t [QDEP-1:0] q_entries,
	input  logic [QDEP-1:0]         q_valid,
	output mem_request_t            ldo,
	output logic                    found
);

	logic             is_load;
	logic [LANES-1:0] ld_lanes;
	logic [LANES-1:0] ld_bytes;
	logic [DAT_W-1:0] dmask;
	logic [QDEP-1:0]  hit;
	logic [DAT_W-1:0] st_dat;
	logic [2:0]       st_ofs;
	logic [2:0]       byte_diff;
	logic [DAT_W-1:0] aligned;
	logic [DAT_W-1:0] masked;
	logic             sign;

	// ==========================================================
	// Load decode
	// ==========================================================

	assign is_load = (req.func == MR_LOAD) || (req.func == MR_LOADZ);

	// Lanes the load reads inside its doubleword
	assign ld_lanes = lane_sel(req);

	// Lanes of the result once the data is right-justified
	assign ld_bytes = size_mask(req.size);

	// Expand the byte mask of the result to a bit mask
	always_comb begin
		for (int b = 0; b < LANES; b++) begin
			dmask[b*8 +: 8] = {8{ld_bytes[b]}};
		end
	end

	// ==========================================================
	// Queue match
	// ==========================================================

	// A store matches when it is valid, sits in the same doubleword
	// and its lanes are a superset of the load lanes
	// Partial overlap is not a match and the load goes to the queue
	always_comb begin
		for (int i = 0; i < QDEP; i++) begin
			hit[i] = is_load && q_valid[i] &&
				(q_entries[i].func == MR_STORE) &&
				(q_entries[i].adr[ADR_W-1:3] == req.adr[ADR_W-1:3]) &&
				((lane_sel(q_entries[i]) & ld_lanes) == ld_lanes);
		end
	end

	// Entries are kept in arrival order with the oldest at index 0
	// Scanning upward lets the youngest matching store win
	always_comb begin
		st_dat = '0;
		st_ofs = '0;
		for (int i = 0; i < QDEP; i++) begin
			if (hit[i]) begin
				st_dat = q_entries[i].dat;
				st_ofs = q_entries[i].adr[2:0];
			end
		end
	end

	// ==========================================================
	// Data alignment and extension
	// ==========================================================

	// Covering means the store starts at or below the load address,
	// so the byte difference is never negative on a hit
	assign byte_diff = req.adr[2:0] - st_ofs;

	// Move the first load byte down to lane 0 and drop the rest
	assign aligned = st_dat >> {byte_diff, 3'b000};
	assign masked  = aligned & dmask;

	// Sign bit is the top bit of the most significant loaded byte
	always_comb begin
		case (req.size)
			SZ_BYTE:  sign = aligned[7];
			SZ_WYDE:  sign = aligned[15];
			SZ_TETRA: sign = aligned[31];
			SZ_OCTA:  sign = aligned[DAT_W-1];
			default:  sign = aligned[DAT_W-1];
		endcase
	end

	// Without a hit the request passes through untouched
	always_comb begin
		found = |hit;
		ldo = req;
		if (found) begin
			// Only MR_LOAD fills the upper bytes with the sign
			if (req.func == MR_LOAD && sign) begin
				ldo.dat = masked | ~dmask;
			end else begin
				ldo.dat = masked;
			end
		end
		// Lanes past the top of the doubleword are never searched,
		// so a forwarded load has to end inside its doubleword
		if (found) begin
			a_found_in_dword: assert ((4'(req.adr[2:0]) + (4'd1 << req.size)) <= 4'd8)
				else $error("fwd_search: forwarded load crosses a doubleword");
		end
	end

endmodule

//--- source/store_queue.sv
// ==========================================================
// Shifting memory request queue shared by two request ports.
// Acks forwarded loads without storing them, arbitrates the
// single enqueue slot with port 0 first, drops retried ids
// and shifts toward the head on each read.
// The whole queue is exported for the forwarding search.
// ==========================================================

module store_queue
	import mem_req_pkg::*;
#(
	parameter int QDEP = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wr0,
	input  mem_request_t            req0,
	input  logic                    found0,
	output logic                    wr_ack0,
	input  logic                    wr1,
	input  mem_request_t            req1,
	input  logic                    found1,
	output logic                    wr_ack1,
	input  logic                    rd,
	output mem_request_t [QDEP-1:0] q_entries,
	output logic [QDEP-1:0]         q_valid,
	output mem_request_t            head,
	output logic                    head_valid,
	output logic                    empty
);

	// Count runs from zero to QDEP inclusive
	localparam int CNT_W = $clog2(QDEP + 1);
	localparam int IDX_W = (QDEP > 1) ? $clog2(QDEP) : 1;

	mem_request_t [QDEP-1:0] que;
	logic [QDEP-1:0]         valid_bits;
	logic [QDEP-1:0]         valid_next;
	logic [CNT_W-1:0]        count;
	logic [TID_W-1:0]        last_tid;

	logic             act0;
	logic             act1;
	logic             enq0;
	logic             enq1;
	logic             win;
	mem_request_t     win_req;
	logic             dup;
	logic             do_rd;
	logic             space;
	logic             push;
	logic [CNT_W-1:0] tail;

	// ==========================================================
	// Arbitration
	// ==========================================================

	// A port whose ack is showing is still holding the request it
	// just had accepted, so it is not offering a new one this cycle
	assign act0 = wr0 && !wr_ack0;
	assign act1 = wr1 && !wr_ack1;

	// Port 0 takes the enqueue slot whenever it has an unfound request
	assign enq0 = act0 && !found0;
	assign enq1 = act1 && !found1 && !enq0;
	assign win = enq0 || enq1;
	assign win_req = enq0 ? req0 : req1;

	// Reads of an empty queue are ignored
	assign do_rd = rd && head_valid;

	// A read in the same cycle frees the slot the new entry needs
	assign space = (count < CNT_W'(QDEP)) || do_rd;

	// Same id as the last stored request means a retry
	assign dup = (win_req.tid == last_tid);
	assign push = win && !dup && space;

	// Tail slot after any shift caused by the read
	assign tail = do_rd ? count - 1'b1 : count;

	always_comb begin
		valid_next = do_rd ? (valid_bits >> 1) : valid_bits;
		if (push) begin
			valid_next[tail[IDX_W-1:0]] = 1'b1;
		end
	end

	// ==========================================================
	// Control state
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ack0 <= 1'b0;
			wr_ack1 <= 1'b0;
			valid_bits <= '0;
			count <= '0;
			last_tid <= '1;
		end else begin
			// Found loads are acked at once, the winner when it is stored or dropped
			wr_ack0 <= (act0 && found0) || (enq0 && (dup || space));
			wr_ack1 <= (act1 && found1) || (enq1 && (dup || space));
			valid_bits <= valid_next;
			count <= count + CNT_W'(push) - CNT_W'(do_rd);
			if (push) begin
				last_tid <= win_req.tid;
			end
		end
	end

	// Entry storage shifts toward index 0 on a read
	// The write at the tail comes last so it wins on the top slot
	always_ff @(posedge clk) begin
		if (do_rd) begin
			for (int i = 0; i < QDEP - 1; i++) begin
				que[i] <= que[i+1];
			end
		end
		if (push) begin
			que[tail[IDX_W-1:0]] <= win_req;
		end
	end

	// ==========================================================
	// Outputs
	// ==========================================================

	assign q_entries = que;
	assign q_valid = valid_bits;
	assign head = que[0];
	assign head_valid = valid_bits[0];
	assign empty = ~|valid_bits;

	// Count and valid bits are kept separately and must agree
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(QDEP))
		else $error("store_queue: count above queue depth");

	a_head_valid: assert property (@(posedge clk) disable iff (rst)
		head_valid == (count != '0))
		else $error("store_queue: head_valid disagrees with count");

	// A full queue without a read keeps its contents for the next cycle
	a_full_hold: assert property (@(posedge clk) disable iff (rst)
		(count == CNT_W'(QDEP) && !rd) |=> (count == CNT_W'(QDEP)) && $stable(q_valid))
		else $error("store_queue: entry added to a full queue");

endmodule

//--- source/mem_req_queue_top.sv
// ==========================================================
// Top level of the memory request queue.
// Two load/store ports offer requests with wr and req, and the
// memory side drains the queue through head and rd.
// One forwarding search per port runs against the queue.
// ==========================================================

module mem_req_queue_top
	import mem_req_pkg::*;
#(
	parameter int QDEP = 8
) (
	input  logic         clk,
	input  logic         rst,
	// Port 0
	input  logic         wr0,
	input  mem_request_t req0,
	output logic         wr_ack0,
	output mem_request_t ldo0,
	output logic         found0,
	// Port 1
	input  logic         wr1,
	input  mem_request_t req1,
	output logic         wr_ack1,
	output mem_request_t ldo1,
	output logic         found1,
	// Memory side
	input  logic         rd,
	output mem_request_t head,
	output logic         head_valid,
	output logic         empty
);

	// Snapshot of the queue seen by both searches
	mem_request_t [QDEP-1:0] q_entries;
	logic [QDEP-1:0]         q_valid;

	// Search for port 0
	fwd_search #(
		.QDEP(QDEP)
	) u_search0 (
		.req      (req0),
		.q_entries(q_entries),
		.q_valid  (q_valid),
		.ldo      (ldo0),
		.found    (found0)
	);

	// Search for port 1
	fwd_search #(
		.QDEP(QDEP)
	) u_search1 (
		.req      (req1),
		.q_entries(q_entries),
		.q_valid  (q_valid),
		.ldo      (ldo1),
		.found    (found1)
	);

	// Both found flags steer the queue away from storing forwarded loads
	store_queue #(
		.QDEP(QDEP)
	) u_queue (
		.clk       (clk),
		.rst       (rst),
		.wr0       (wr0),
		.req0      (req0),
		.found0    (found0),
		.wr_ack0   (wr_ack0),
		.wr1       (wr1),
		.req1      (req1),
		.found1    (found1),
		.wr_ack1   (wr_ack1),
		.rd        (rd),
		.q_entries (q_entries),
		.q_valid   (q_valid),
		.head      (head),
		.head_valid(head_valid),
		.empty     (empty)
	);

endmodule

//--- include/tb_ref_model.svh
// ==========================================================
// Reference model of the memory request queue for the testbench.
// Include it inside the testbench module after importing
// mem_req_pkg. Call model_reset during reset, model_forward for
// the expected search result of a port and model_step once at
// every rising edge with the inputs of the ending cycle.
// ==========================================================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Model queue with the oldest entry at index 0
mem_request_t m_que[$];
logic [TID_W-1:0] m_last_tid;
// Acks the DUT should show in the current cycle
logic m_ack0;
logic m_ack1;

function automatic void model_reset();
	m_que.delete();
	m_last_tid = '1;
	m_ack0 = 1'b0;
	m_ack1 = 1'b0;
endfunction

// Expected forwarding result, built byte by byte from the youngest covering store
function automatic void model_forward(input mem_request_t req, output logic found,
	output mem_request_t ldo);
	int nbytes;
	int ofs;
	mem_request_t st;
	found = 1'b0;
	ldo = req;
	nbytes = 1 << req.size;
	if (req.func == MR_STORE) begin
		return;
	end
	for (int i = m_que.size() - 1; i >= 0; i--) begin
		st = m_que[i];
		if (!found && st.func == MR_STORE && st.adr[ADR_W-1:3] == req.adr[ADR_W-1:3] &&
			(lane_sel(st) & lane_sel(req)) == lane_sel(req)) begin
			found = 1'b1;
			ofs = int'(req.adr[2:0]) - int'(st.adr[2:0]);
			ldo.dat = '0;
			for (int b = 0; b < nbytes; b++) begin
				ldo.dat[b*8 +: 8] = st.dat[(ofs + b)*8 +: 8];
			end
			if (req.func == MR_LOAD && ldo.dat[nbytes*8 - 1]) begin
				for (int b = nbytes; b < LANES; b++) begin
					ldo.dat[b*8 +: 8] = 8'hff;
				end
			end
		end
	end
endfunction

// Advance the model by one clock and set the acks expected next cycle
function automatic void model_step(input logic wr0, input mem_request_t req0,
	input logic wr1, input mem_request_t req1, input logic rd, input int depth);
	logic f0;
	logic f1;
	logic a0;
	logic a1;
	logic e0;
	logic e1;
	logic dup;
	logic space;
	mem_request_t l0;
	mem_request_t l1;
	mem_request_t w;
	model_forward(req0, f0, l0);
	model_forward(req1, f1, l1);
	a0 = wr0 && !m_ack0;
	a1 = wr1 && !m_ack1;
	e0 = a0 && !f0;
	e1 = a1 && !f1 && !e0;
	w = e0 ? req0 : req1;
	dup = (w.tid == m_last_tid);
	space = (m_que.size() < depth) || (rd && m_que.size() != 0);
	if (rd && m_que.size() != 0) begin
		void'(m_que.pop_front());
	end
	if ((e0 || e1) && !dup && space) begin
		m_que.push_back(w);
		m_last_tid = w.tid;
	end
	m_ack0 = (a0 && f0) || (e0 && (dup || space));
	m_ack1 = (a1 && f1) || (e1 && (dup || space));
endfunction

`endif

//--- tests/tb_mem_req_queue.sv
// ==========================================================
// Testbench of the memory request queue top level.
// Drives both request ports and the read side, mirrors the
// queue in the included reference model and compares every
// DUT output once per cycle. Ends with one result line.
// ==========================================================

module tb_mem_req_queue
	import mem_req_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int QDEP = 8;
	localparam int TIMEOUT = 50;

	logic clk;
	logic rst;
	logic wr0;
	mem_request_t req0;
	logic wr_ack0;
	mem_request_t ldo0;
	logic found0;
	logic wr1;
	mem_request_t req1;
	logic wr_ack1;
	mem_request_t ldo1;
	logic found1;
	logic rd;
	mem_request_t head;
	logic head_valid;
	logic empty;

	int errors;
	int timeouts;
	bit aborted;
	logic [31:0] lcg_state;
	logic [TID_W-1:0] tid_next;

	`include "tb_ref_model.svh"

	mem_req_queue_top #(
		.QDEP(QDEP)
	) i_dut (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ==========================================================
	// Helpers
	// ==========================================================

	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// Later drivers see the abort flag and return at once
	task automatic timeout_hit(input string msg);
		$display("Timeout after %0d cycles: %s", TIMEOUT, msg);
		timeouts++;
		aborted = 1'b1;
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Every new request gets a fresh transaction id
	function automatic mem_request_t make_req(input mem_func_e func, input mem_size_e size,
		input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
		mem_request_t r;
		r.tid = tid_next;
		r.func = func;
		r.size = size;
		r.adr = adr;
		r.dat = dat;
		tid_next = tid_next + 8'd1;
		return r;
	endfunction

	function automatic mem_request_t rand_req(input mem_func_e func);
		mem_size_e sz;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
		sz = mem_size_e'(2'(lcg_next() >> 30));
		// Four doublewords only, so random loads often meet queued stores
		adr = 32'h0000_0800 + ((lcg_next() >> 8) & 32'h18) + ((lcg_next() >> 8) & 32'h7);
		adr = adr & ~((32'd1 << sz) - 32'd1);
		dat = {lcg_next(), lcg_next()};
		return make_req(func, sz, adr, dat);
	endfunction

	// ==========================================================
	// Port and read side drivers
	// ==========================================================

	// Holds a request on one port until its ack shows
	// An exp_found of -1 skips the found check
	task automatic offer(input int port, input mem_request_t r, input int exp_found);
		int n;
		logic ack;
		logic got_found;
		if (aborted) return;
		if (port == 0) begin
			wr0 = 1'b1;
			req0 = r;
		end else begin
			wr1 = 1'b1;
			req1 = r;
		end
		n = 0;
		ack = 1'b0;
		got_found = 1'b0;
		while (!ack && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
			ack = (port == 0) ? wr_ack0 : wr_ack1;
			got_found = (port == 0) ? found0 : found1;
		end
		wr0 = (port == 0) ? 1'b0 : wr0;
		wr1 = (port == 1) ? 1'b0 : wr1;
		if (!ack) begin
			timeout_hit($sformatf("no ack on port %0d for tid %0d", port, r.tid));
		end else if (exp_found >= 0 && got_found !== exp_found[0]) begin
			report_error($sformatf("port %0d tid %0d found %b, expected %0d",
				port, r.tid, got_found, exp_found));
		end
	endtask

	// Both ports offer in the same cycle and port 0 must be served first
	task automatic offer_pair(input mem_request_t r0, input mem_request_t r1);
		int n;
		int c0;
		int c1;
		if (aborted) return;
		wr0 = 1'b1;
		req0 = r0;
		wr1 = 1'b1;
		req1 = r1;
		c0 = -1;
		c1 = -1;
		n = 0;
		while ((c0 < 0 || c1 < 0) && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
			if (c0 < 0 && wr_ack0) begin
				c0 = n;
				wr0 = 1'b0;
			end
			if (c1 < 0 && wr_ack1) begin
				c1 = n;
				wr1 = 1'b0;
			end
		end
		wr0 = 1'b0;
		wr1 = 1'b0;
		if (c0 < 0 || c1 < 0) begin
			timeout_hit("both ports offered together and one was never acked");
		end else begin
			if (c0 != 1) begin
				report_error($sformatf("port 0 acked after %0d cycles, expected 1", c0));
			end
			if (c1 <= c0) begin
				report_error($sformatf("port 1 acked in cycle %0d, port 0 in %0d", c1, c0));
			end
		end
	endtask

	// Reads until the queue is empty and returns how many entries left
	task automatic drain(output int popped);
		int n;
		popped = 0;
		n = 0;
		if (aborted) return;
		rd = 1'b1;
		while (head_valid && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
			popped++;
		end
		rd = 1'b0;
		if (head_valid) timeout_hit("queue still holds entries while reading");
	endtask

	// ==========================================================
	// Model update and comparison
	// ==========================================================

	// Inputs change 1 ns after the edge, so the edge sees the whole cycle
	always @(posedge clk) begin
		if (rst) begin
			model_reset();
		end else begin
			model_step(wr0, req0, wr1, req1, rd, QDEP);
		end
	end

	// Falling edge sits mid-cycle where every output has settled
	always @(negedge clk) begin
		logic ef0;
		logic ef1;
		mem_request_t el0;
		mem_request_t el1;
		if (!rst) begin
			model_forward(req0, ef0, el0);
			model_forward(req1, ef1, el1);
			if (found0 !== ef0) report_error($sformatf("found0 %b, expected %b", found0, ef0));
			if (ldo0 !== el0) report_error($sformatf("ldo0 %h, expected %h", ldo0, el0));
			if (found1 !== ef1) report_error($sformatf("found1 %b, expected %b", found1, ef1));
			if (ldo1 !== el1) report_error($sformatf("ldo1 %h, expected %h", ldo1, el1));
			if (wr_ack0 !== m_ack0) begin
				report_error($sformatf("wr_ack0 %b, expected %b", wr_ack0, m_ack0));
			end
			if (wr_ack1 !== m_ack1) begin
				report_error($sformatf("wr_ack1 %b, expected %b", wr_ack1, m_ack1));
			end
			if (head_valid !== (m_que.size() != 0)) begin
				report_error("head_valid disagrees with model");
			end
			if (empty !== (m_que.size() == 0)) report_error("empty disagrees with model");
			if (m_que.size() != 0 && head !== m_que[0]) begin
				report_error($sformatf("head %h, expected %h", head, m_que[0]));
			end
		end
	end

	// ==========================================================
	// Stimulus
	// ==========================================================

	initial begin
		int popped;
		int expect_n;
		mem_request_t last;
		mem_request_t r;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		lcg_state = 32'hb06f880a;
		tid_next = '0;
		rst = 1'b1;
		wr0 = 1'b0;
		req0 = '0;
		wr1 = 1'b0;
		req1 = '0;
		rd = 1'b0;
		model_reset();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// Reset values
		if (empty !== 1'b1 || head_valid !== 1'b0 ||
			wr_ack0 !== 1'b0 || wr_ack1 !== 1'b0) begin
			report_error("outputs after reset are not empty and idle");
		end

		// Stores from both ports, including a same-cycle pair, drain in order
		for (int i = 0; i < 4; i++) begin
			offer(i % 2, rand_req(MR_STORE), -1);
		end
		offer_pair(rand_req(MR_STORE), rand_req(MR_STORE));
		drain(popped);
		if (popped != 6) report_error($sformatf("drained %0d stores, expected 6", popped));

		// Covered loads where the younger tetra store wins at 0x104
		offer(0, make_req(MR_STORE, SZ_OCTA, 32'h100, 64'h8877_6655_4433_2211), -1);
		offer(1, make_req(MR_STORE, SZ_TETRA, 32'h104, 64'h0000_0000_f0e0_d0c0), -1);
		offer(0, make_req(MR_LOAD, SZ_BYTE, 32'h105, '0), 1);
		if (ldo0.dat !== 64'hffff_ffff_ffff_ffd0) report_error("sign-extended byte load wrong");
		offer(1, make_req(MR_LOADZ, SZ_BYTE, 32'h105, '0), 1);
		if (ldo1.dat !== 64'h0000_0000_0000_00d0) report_error("zero-extended byte load wrong");
		offer(0, make_req(MR_LOAD, SZ_WYDE, 32'h102, '0), 1);
		if (ldo0.dat !== 64'h0000_0000_0000_4433) report_error("wyde load from octa store wrong");
		offer(1, make_req(MR_LOAD, SZ_TETRA, 32'h104, '0), 1);
		if (ldo1.dat !== 64'hffff_ffff_f0e0_d0c0) begin
			report_error("tetra load from younger store wrong");
		end
		drain(popped);

		// Partial cover, other doubleword and empty queue all go to the queue
		offer(0, make_req(MR_STORE, SZ_WYDE, 32'h204, 64'h1234), -1);
		offer(1, make_req(MR_LOAD, SZ_TETRA, 32'h204, '0), 0);
		offer(0, make_req(MR_LOADZ, SZ_BYTE, 32'h30c, '0), 0);
		drain(popped);
		if (popped != 3) report_error($sformatf("drained %0d entries, expected 3", popped));
		offer(1, make_req(MR_LOAD, SZ_OCTA, 32'h400, '0), 0);
		drain(popped);

		// A full queue holds a new store until a read frees a slot
		for (int i = 0; i < QDEP; i++) begin
			offer(i % 2, rand_req(MR_STORE), -1);
		end
		last = rand_req(MR_STORE);
		wr0 = 1'b1;
		req0 = last;
		repeat (5) begin
			@(posedge clk);
			#1;
			if (wr_ack0 !== 1'b0) report_error("store acked while the queue was full");
		end
		rd = 1'b1;
		@(posedge clk);
		#1;
		rd = 1'b0;
		if (wr_ack0 !== 1'b1) report_error("store not acked after read freed a slot");
		wr0 = 1'b0;

		// A retry of the last id is acked even when full and adds nothing
		r = rand_req(MR_STORE);
		r.tid = last.tid;
		offer(1, r, -1);
		expect_n = m_que.size();
		drain(popped);
		if (popped != expect_n || popped != QDEP) begin
			report_error($sformatf("drained %0d, model %0d, expected %0d", popped, expect_n, QDEP));
		end

		// Random mix of stores and loads on both ports
		for (int i = 0; i < 24; i++) begin
			if (m_que.size() == QDEP) drain(popped);
			offer(int'(lcg_next() >> 31), rand_req(mem_func_e'(2'(lcg_next() % 3))), -1);
		end
		drain(popped);

		repeat (2) @(posedge clk);
		$display("Finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
source/mem_req_pkg.sv
source/fwd_search.sv
source/store_queue.sv
source/mem_req_queue_top.sv
tests/tb_mem_req_queue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory request queue testbench with Verilator and runs it.
# The exit status is nonzero unless the simulation reports a pass.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_req_queue -f compile.f \
	-Mdir obj_dir -o sim_mem_req_queue &&
./obj_dir/sim_mem_req_queue | tee /dev/stderr | grep -qx "Test passed" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
